// File: common/demodPkg.sv
`default_nettype none

package demodPkg;

    //////////////////////////////////////////////////////////////////////
    // Widths
    //////////////////////////////////////////////////////////////////////
    localparam int SAMPLE_W  = 18;  // Samples and DAC words
    localparam int DET_W     = 8;   // Detector freq words
    localparam int MAG_W     = 9;   // Detector magnitude
    localparam int MAG_ACC_W = 24;  // Magnitude loop accumulator
    localparam int ALPHA_W   = 16;  // False-lock alpha and threshold
    localparam int BUS_W     = 32;  // Wishbone data
    localparam int ADR_W     = 4;   // Wishbone word address

    //////////////////////////////////////////////////////////////////////
    // Encodings
    //////////////////////////////////////////////////////////////////////
    typedef enum logic [3:0] {
        MODE_AM    = 4'd0,
        MODE_PM    = 4'd1,
        MODE_FM    = 4'd2,
        MODE_BPSK  = 4'd3,
        MODE_QPSK  = 4'd4,
        MODE_OQPSK = 4'd5
    } demodModeT;

    // Codes 8 to 15 fall back to DAC_I
    typedef enum logic [3:0] {
        DAC_I         = 4'd0,
        DAC_Q         = 4'd1,
        DAC_ISYM      = 4'd2,
        DAC_QSYM      = 4'd3,
        DAC_FREQ      = 4'd4,
        DAC_FREQERROR = 4'd5,
        DAC_MAG       = 4'd6,
        DAC_AVGFREQ   = 4'd7
    } dacSelT;

    typedef enum logic [3:0] {
        REG_CONTROL   = 4'd0,  // Mode [3:0], iqSwap [4]
        REG_DACSEL    = 4'd1,  // DAC0 [3:0], DAC1 [7:4], DAC2 [11:8]
        REG_FALSELOCK = 4'd2,  // Alpha [15:0], threshold [31:16]
        REG_MAGTC     = 4'd3,  // amTC [4:0]
        REG_STATUS    = 4'd4   // Read only, highFreqOffset [0]
    } regAddrT;

endpackage

`default_nettype wire

// File: src/demodRegs.sv
`timescale 1ns/10ps
`default_nettype none

module demodRegs import demodPkg::*; (
    input  logic               clk,
    input  logic               arstN,
    input  logic               wbCyc,
    input  logic               wbStb,
    input  logic               wbWe,
    input  logic [ADR_W-1:0]   wbAdr,
    input  logic [3:0]         wbSel,
    input  logic [BUS_W-1:0]   wbDatW,
    output logic [BUS_W-1:0]   wbDatR,
    output logic               wbAck,
    input  logic               highFreqOffset,
    output demodModeT          demodMode,
    output logic               iqSwap,
    output dacSelT             dac0Select,
    output dacSelT             dac1Select,
    output dacSelT             dac2Select,
    output logic [ALPHA_W-1:0] falseLockAlpha,
    output logic [ALPHA_W-1:0] falseLockThreshold,
    output logic [4:0]         amTC
);

    logic             access;
    logic [BUS_W-1:0] readData;

    assign access = wbCyc & wbStb & ~wbAck;  // New cycle, no wait states

    always_comb begin
        readData = '0;  // Unmapped bits and addresses read zero
        case (regAddrT'(wbAdr))
            REG_CONTROL:   readData[4:0] = {iqSwap, demodMode};
            REG_DACSEL:    readData[11:0] = {dac2Select, dac1Select, dac0Select};
            REG_FALSELOCK: readData = {falseLockThreshold, falseLockAlpha};
            REG_MAGTC:     readData[4:0] = amTC;
            REG_STATUS:    readData[0] = highFreqOffset;
            default:       readData = '0;
        endcase
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            wbAck              <= 1'b0;
            wbDatR             <= '0;
            demodMode          <= MODE_AM;
            iqSwap             <= 1'b0;
            dac0Select         <= DAC_I;
            dac1Select         <= DAC_I;
            dac2Select         <= DAC_I;
            falseLockAlpha     <= '0;
            falseLockThreshold <= '0;
            amTC               <= '0;
        end else begin
            wbAck <= access;  // Single-cycle classic ack
            if (access) begin
                wbDatR <= readData;
            end
            if (access && wbWe) begin
                case (regAddrT'(wbAdr))
                    REG_CONTROL: begin
                        if (wbSel[0]) begin
                            demodMode <= demodModeT'(wbDatW[3:0]);
                            iqSwap    <= wbDatW[4];
                        end
                    end
                    REG_DACSEL: begin
                        if (wbSel[0]) begin
                            dac0Select <= dacSelT'(wbDatW[3:0]);
                            dac1Select <= dacSelT'(wbDatW[7:4]);
                        end
                        if (wbSel[1]) dac2Select <= dacSelT'(wbDatW[11:8]);
                    end
                    REG_FALSELOCK: begin
                        if (wbSel[0]) falseLockAlpha[7:0]      <= wbDatW[7:0];
                        if (wbSel[1]) falseLockAlpha[15:8]     <= wbDatW[15:8];
                        if (wbSel[2]) falseLockThreshold[7:0]  <= wbDatW[23:16];
                        if (wbSel[3]) falseLockThreshold[15:8] <= wbDatW[31:24];
                    end
                    REG_MAGTC: begin
                        if (wbSel[0]) amTC <= wbDatW[4:0];
                    end
                    default: ;  // Status and unmapped are read only
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// File: falseLock/falseLockDetector.sv
`timescale 1ns/10ps
`default_nettype none

module falseLockDetector import demodPkg::*; (
    input  logic                       clk,
    input  logic                       arstN,
    input  logic                       ddcSync,
    input  demodModeT                  demodMode,
    input  logic [DET_W-1:0]           freq,
    input  logic [DET_W-1:0]           freqError,
    input  logic [ALPHA_W-1:0]         falseLockAlpha,
    input  logic [ALPHA_W-1:0]         falseLockThreshold,
    output logic signed [SAMPLE_W-1:0] averageFreq,
    output logic                       highFreqOffset
);

    logic signed [SAMPLE_W-1:0]   freqSample;
    logic        [DET_W-1:0]      freqSel;
    logic signed [SAMPLE_W:0]     alphaQ17;       // Q17, kept positive
    logic signed [SAMPLE_W:0]     oneMinusAlpha;
    logic signed [2*SAMPLE_W+1:0] weightedSum;
    logic        [SAMPLE_W-1:0]   absAverage;

    assign freqSel       = (demodMode == MODE_OQPSK) ? freq : freqError;
    assign alphaQ17      = {1'b0, falseLockAlpha, 2'b00};
    assign oneMinusAlpha = 19'sh20000 - alphaQ17;

    // Lag average, alpha*x + (1 - alpha)*avg
    assign weightedSum = freqSample * alphaQ17 + averageFreq * oneMinusAlpha;
    assign absAverage  = averageFreq[SAMPLE_W-1] ? -averageFreq : averageFreq;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            freqSample     <= '0;
            averageFreq    <= '0;
            highFreqOffset <= 1'b0;
        end else if (ddcSync) begin
            freqSample     <= {freqSel, {(SAMPLE_W-DET_W){1'b0}}};  // Left aligned
            averageFreq    <= weightedSum[SAMPLE_W+16:17];          // Drop Q17 scale
            highFreqOffset <= (absAverage > falseLockThreshold);    // Uses old average
        end
    end

endmodule

`default_nettype wire

// File: src/magFilter.sv
`timescale 1ns/10ps
`default_nettype none

module magFilter import demodPkg::*; (
    input  logic                clk,
    input  logic                arstN,
    input  logic                ddcSync,
    input  logic [MAG_W-1:0]    mag,
    input  logic [4:0]          amTC,
    output logic [SAMPLE_W-1:0] magLevel
);

    logic signed [MAG_W:0]     magError;
    logic        [MAG_ACC_W-1:0] magAccum;
    logic signed [MAG_ACC_W-1:0] magStep;
    logic        [4:0]         shiftAmt;

    // Loop gain, larger amTC gives a slower loop
    assign shiftAmt = (amTC > 5'd14) ? 5'd0 : 5'd14 - amTC;
    assign magStep  = MAG_ACC_W'(magError) <<< shiftAmt;  // Sign extended
    assign magLevel = magAccum[MAG_ACC_W-1 -: SAMPLE_W];

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            magError <= '0;
            magAccum <= '0;
        end else if (ddcSync) begin
            magError <= {1'b0, mag} - magAccum[MAG_ACC_W-1 -: MAG_W+1];
            magAccum <= magAccum + magStep;  // Wraps like the error
        end
    end

endmodule

`default_nettype wire

// File: src/oqpskDeskew.sv
`timescale 1ns/10ps
`default_nettype none

module oqpskDeskew import demodPkg::*; (
    input  logic                clk,
    input  logic                arstN,
    input  logic                resampSync,
    input  demodModeT           demodMode,
    input  logic [SAMPLE_W-1:0] iResamp,
    input  logic [SAMPLE_W-1:0] qResamp,
    output logic [SAMPLE_W-1:0] iSym,
    output logic [SAMPLE_W-1:0] qSym,
    output logic                symSync
);

    logic [SAMPLE_W-1:0] qDelay;  // Q half a symbol back

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            iSym    <= '0;
            qSym    <= '0;
            qDelay  <= '0;
            symSync <= 1'b0;
        end else begin
            symSync <= resampSync;
            if (resampSync) begin
                iSym   <= iResamp;
                qDelay <= qResamp;
                qSym   <= (demodMode == MODE_OQPSK) ? qDelay : qResamp;
            end
        end
    end

endmodule

`default_nettype wire

// File: dacMux/dacChannel.sv
`timescale 1ns/10ps
`default_nettype none

module dacChannel import demodPkg::*; (
    input  logic                clk,
    input  logic                arstN,
    input  dacSelT              dacSelect,
    input  logic                ddcSyncD,
    input  logic                symSync,
    input  logic [SAMPLE_W-1:0] iSwap,
    input  logic [SAMPLE_W-1:0] qSwap,
    input  logic [SAMPLE_W-1:0] iSym,
    input  logic [SAMPLE_W-1:0] qSym,
    input  logic [SAMPLE_W-1:0] freqWord,
    input  logic [SAMPLE_W-1:0] freqErrorWord,
    input  logic [SAMPLE_W-1:0] magLevel,
    input  logic [SAMPLE_W-1:0] averageFreq,
    output logic [SAMPLE_W-1:0] dacData,
    output logic                dacSync
);

    logic [SAMPLE_W-1:0] selData;
    logic                selSync;

    always_comb begin
        selSync = ddcSyncD;  // Most sources run at the DDC rate
        case (dacSelect)
            DAC_Q:         selData = qSwap;
            DAC_ISYM: begin
                selData = iSym;
                selSync = symSync;
            end
            DAC_QSYM: begin
                selData = qSym;
                selSync = symSync;
            end
            DAC_FREQ:      selData = freqWord;
            DAC_FREQERROR: selData = freqErrorWord;
            DAC_MAG:       selData = magLevel;
            DAC_AVGFREQ:   selData = averageFreq;
            default:       selData = iSwap;  // DAC_I and unknown codes
        endcase
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            dacData <= '0;
            dacSync <= 1'b0;
        end else begin
            dacData <= selData;
            dacSync <= selSync;
        end
    end

endmodule

`default_nettype wire

// File: dacMux/dacMux.sv
`timescale 1ns/10ps
`default_nettype none

module dacMux import demodPkg::*; (
    input  logic                clk,
    input  logic                arstN,
    input  logic                ddcSync,
    input  logic                iqSwap,
    input  logic [SAMPLE_W-1:0] iDdc,
    input  logic [SAMPLE_W-1:0] qDdc,
    input  logic [DET_W-1:0]    freq,
    input  logic [DET_W-1:0]    freqError,
    input  logic [SAMPLE_W-1:0] iSym,
    input  logic [SAMPLE_W-1:0] qSym,
    input  logic                symSync,
    input  logic [SAMPLE_W-1:0] magLevel,
    input  logic [SAMPLE_W-1:0] averageFreq,
    input  dacSelT              dac0Select,
    input  dacSelT              dac1Select,
    input  dacSelT              dac2Select,
    output logic [SAMPLE_W-1:0] dac0Data,
    output logic                dac0Sync,
    output logic [SAMPLE_W-1:0] dac1Data,
    output logic                dac1Sync,
    output logic [SAMPLE_W-1:0] dac2Data,
    output logic                dac2Sync
);

    logic [SAMPLE_W-1:0] iSwap;
    logic [SAMPLE_W-1:0] qSwap;
    logic [SAMPLE_W-1:0] freqWord;
    logic [SAMPLE_W-1:0] freqErrorWord;
    logic                ddcSyncD;

    //////////////////////////////////////////////////////////////////////
    // DDC-rate sources, aligned with magLevel and averageFreq
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            iSwap         <= '0;
            qSwap         <= '0;
            freqWord      <= '0;
            freqErrorWord <= '0;
            ddcSyncD      <= 1'b0;
        end else begin
            ddcSyncD <= ddcSync;
            if (ddcSync) begin
                iSwap         <= iqSwap ? qDdc : iDdc;
                qSwap         <= iqSwap ? iDdc : qDdc;
                freqWord      <= {freq, {(SAMPLE_W-DET_W){1'b0}}};
                freqErrorWord <= {freqError, {(SAMPLE_W-DET_W){1'b0}}};
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Monitor channels
    //////////////////////////////////////////////////////////////////////
    dacChannel i_dac0 (
        .clk(clk), .arstN(arstN), .dacSelect(dac0Select),
        .ddcSyncD(ddcSyncD), .symSync(symSync),
        .iSwap(iSwap), .qSwap(qSwap), .iSym(iSym), .qSym(qSym),
        .freqWord(freqWord), .freqErrorWord(freqErrorWord),
        .magLevel(magLevel), .averageFreq(averageFreq),
        .dacData(dac0Data), .dacSync(dac0Sync)
    );

    dacChannel i_dac1 (
        .clk(clk), .arstN(arstN), .dacSelect(dac1Select),
        .ddcSyncD(ddcSyncD), .symSync(symSync),
        .iSwap(iSwap), .qSwap(qSwap), .iSym(iSym), .qSym(qSym),
        .freqWord(freqWord), .freqErrorWord(freqErrorWord),
        .magLevel(magLevel), .averageFreq(averageFreq),
        .dacData(dac1Data), .dacSync(dac1Sync)
    );

    dacChannel i_dac2 (
        .clk(clk), .arstN(arstN), .dacSelect(dac2Select),
        .ddcSyncD(ddcSyncD), .symSync(symSync),
        .iSwap(iSwap), .qSwap(qSwap), .iSym(iSym), .qSym(qSym),
        .freqWord(freqWord), .freqErrorWord(freqErrorWord),
        .magLevel(magLevel), .averageFreq(averageFreq),
        .dacData(dac2Data), .dacSync(dac2Sync)
    );

endmodule

`default_nettype wire

// File: src/demodTop.sv
`timescale 1ns/10ps
`default_nettype none

module demodTop import demodPkg::*; (
    input  logic                clk,
    input  logic                arstN,
    // Wishbone slave
    input  logic                wbCyc,
    input  logic                wbStb,
    input  logic                wbWe,
    input  logic [ADR_W-1:0]    wbAdr,
    input  logic [3:0]          wbSel,
    input  logic [BUS_W-1:0]    wbDatW,
    output logic [BUS_W-1:0]    wbDatR,
    output logic                wbAck,
    // Downconverter and detector
    input  logic [SAMPLE_W-1:0] iDdc,
    input  logic [SAMPLE_W-1:0] qDdc,
    input  logic                ddcSync,
    input  logic [DET_W-1:0]    freq,
    input  logic [DET_W-1:0]    freqError,
    input  logic [MAG_W-1:0]    mag,
    // Resampler
    input  logic [SAMPLE_W-1:0] iResamp,
    input  logic [SAMPLE_W-1:0] qResamp,
    input  logic                resampSync,
    output logic [SAMPLE_W-1:0] iSym,
    output logic [SAMPLE_W-1:0] qSym,
    output logic                symSync,
    output logic                highFreqOffset,
    output demodModeT           demodMode,
    // DAC monitors
    output logic [SAMPLE_W-1:0] dac0Data,
    output logic                dac0Sync,
    output logic [SAMPLE_W-1:0] dac1Data,
    output logic                dac1Sync,
    output logic [SAMPLE_W-1:0] dac2Data,
    output logic                dac2Sync
);

    logic                iqSwap;
    dacSelT              dac0Select;
    dacSelT              dac1Select;
    dacSelT              dac2Select;
    logic [ALPHA_W-1:0]  falseLockAlpha;
    logic [ALPHA_W-1:0]  falseLockThreshold;
    logic [4:0]          amTC;
    logic [SAMPLE_W-1:0] averageFreq;
    logic [SAMPLE_W-1:0] magLevel;

    demodRegs i_regs (
        .clk(clk), .arstN(arstN),
        .wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe), .wbAdr(wbAdr),
        .wbSel(wbSel), .wbDatW(wbDatW), .wbDatR(wbDatR), .wbAck(wbAck),
        .highFreqOffset(highFreqOffset), .demodMode(demodMode), .iqSwap(iqSwap),
        .dac0Select(dac0Select), .dac1Select(dac1Select), .dac2Select(dac2Select),
        .falseLockAlpha(falseLockAlpha), .falseLockThreshold(falseLockThreshold),
        .amTC(amTC)
    );

    falseLockDetector i_falseLock (
        .clk(clk), .arstN(arstN), .ddcSync(ddcSync), .demodMode(demodMode),
        .freq(freq), .freqError(freqError),
        .falseLockAlpha(falseLockAlpha), .falseLockThreshold(falseLockThreshold),
        .averageFreq(averageFreq), .highFreqOffset(highFreqOffset)
    );

    magFilter i_magFilter (
        .clk(clk), .arstN(arstN), .ddcSync(ddcSync),
        .mag(mag), .amTC(amTC), .magLevel(magLevel)
    );

    oqpskDeskew i_deskew (
        .clk(clk), .arstN(arstN), .resampSync(resampSync), .demodMode(demodMode),
        .iResamp(iResamp), .qResamp(qResamp),
        .iSym(iSym), .qSym(qSym), .symSync(symSync)
    );

    dacMux i_dacMux (
        .clk(clk), .arstN(arstN), .ddcSync(ddcSync), .iqSwap(iqSwap),
        .iDdc(iDdc), .qDdc(qDdc), .freq(freq), .freqError(freqError),
        .iSym(iSym), .qSym(qSym), .symSync(symSync),
        .magLevel(magLevel), .averageFreq(averageFreq),
        .dac0Select(dac0Select), .dac1Select(dac1Select), .dac2Select(dac2Select),
        .dac0Data(dac0Data), .dac0Sync(dac0Sync),
        .dac1Data(dac1Data), .dac1Sync(dac1Sync),
        .dac2Data(dac2Data), .dac2Sync(dac2Sync)
    );

endmodule

`default_nettype wire

// File: dv/demodTb.sv
`timescale 1ns/10ps
`default_nettype none

module demodTb import demodPkg::*; ;

    logic                clk = 1'b0;
    logic                arstN;
    logic                wbCyc, wbStb, wbWe;
    logic [ADR_W-1:0]    wbAdr;
    logic [3:0]          wbSel;
    logic [BUS_W-1:0]    wbDatW;
    logic [BUS_W-1:0]    wbDatR;
    logic                wbAck;
    logic [SAMPLE_W-1:0] iDdc, qDdc, iResamp, qResamp;
    logic                ddcSync, resampSync;
    logic [DET_W-1:0]    freq, freqError;
    logic [MAG_W-1:0]    mag;
    logic [SAMPLE_W-1:0] iSym, qSym;
    logic                symSync, highFreqOffset;
    logic [3:0]          demodMode;
    logic [SAMPLE_W-1:0] dac0Data, dac1Data, dac2Data;
    logic                dac0Sync, dac1Sync, dac2Sync;

    logic                streamOn;          // Strobes only run while set
    logic [31:0]         regShadow [0:3];   // Byte-merged register contents
    int                  errorCount = 0;
    int                  checkCount = 0;
    int                  ackCount = 0;
    int                  accessCount = 0;

    // Reference model state
    logic [SAMPLE_W-1:0] mISwap, mQSwap, mFreqWord, mFreqErrWord;
    logic [SAMPLE_W-1:0] mFreqSample, mAvg, mISym, mQSym, mQDelay;
    logic [SAMPLE_W-1:0] mDac [0:2];
    logic                mDacSync [0:2];
    logic                mDdcSyncD, mSymSync, mHigh;
    logic [MAG_W:0]      mMagErr;
    logic [MAG_ACC_W-1:0] mMagAcc;

    always #2 clk = ~clk;  // 4 ns period

    demodTop i_dut (
        .clk(clk), .arstN(arstN),
        .wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe), .wbAdr(wbAdr), .wbSel(wbSel),
        .wbDatW(wbDatW), .wbDatR(wbDatR), .wbAck(wbAck),
        .iDdc(iDdc), .qDdc(qDdc), .ddcSync(ddcSync),
        .freq(freq), .freqError(freqError), .mag(mag),
        .iResamp(iResamp), .qResamp(qResamp), .resampSync(resampSync),
        .iSym(iSym), .qSym(qSym), .symSync(symSync),
        .highFreqOffset(highFreqOffset), .demodMode(demodMode),
        .dac0Data(dac0Data), .dac0Sync(dac0Sync), .dac1Data(dac1Data), .dac1Sync(dac1Sync),
        .dac2Data(dac2Data), .dac2Sync(dac2Sync)
    );

    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("[ERROR] %0t ns: %s is %h, expected %h", $time, name, actual, expected);
        end
    endtask

    function automatic logic [31:0] expectedRead(input logic [3:0] adr);
        case (adr)
            4'd0:    return regShadow[0] & 32'h1F;
            4'd1:    return regShadow[1] & 32'hFFF;
            4'd2:    return regShadow[2];
            4'd3:    return regShadow[3] & 32'h1F;
            4'd4:    return {31'b0, mHigh};  // Status
            default: return '0;
        endcase
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Wishbone master
    //////////////////////////////////////////////////////////////////////
    task automatic busCycle(input logic we, input logic [3:0] adr, input logic [3:0] sel,
                            input logic [31:0] data, output logic [31:0] rdata);
        int   waitCount;
        logic acked;
        waitCount = 0;
        acked     = 1'b0;
        rdata     = '0;
        @(posedge clk);
        wbCyc  <= 1'b1;
        wbStb  <= 1'b1;
        wbWe   <= we;
        wbAdr  <= adr;
        wbSel  <= sel;
        wbDatW <= data;
        accessCount++;
        while (!acked && waitCount < 16) begin
            @(posedge clk);
            waitCount++;
            if (wbAck) begin
                acked = 1'b1;
                rdata = wbDatR;
            end
        end
        wbCyc <= 1'b0;
        wbStb <= 1'b0;
        wbWe  <= 1'b0;
        if (!acked) begin
            errorCount++;
            $display("Bus cycle to address %0d was never acknowledged", adr);
        end else if (we && adr < 4) begin
            for (int b = 0; b < 4; b++) begin
                if (sel[b]) regShadow[adr][8*b +: 8] = data[8*b +: 8];
            end
        end
    endtask

    task automatic writeReg(input logic [3:0] adr, input logic [31:0] data);
        logic [31:0] unused;
        busCycle(1'b1, adr, 4'hF, data, unused);
    endtask

    task automatic readCheck(input logic [3:0] adr);
        logic [31:0] rdata;
        busCycle(1'b0, adr, 4'hF, '0, rdata);
        checkValue($sformatf("wbDatR@%0d", adr), rdata, expectedRead(adr));
        checkValue("demodMode", demodMode, regShadow[0][3:0]);
    endtask

    // Strobes run and then stop long enough for the DAC pipeline to drain
    task automatic runStream(input int cycles);
        streamOn <= 1'b1;
        repeat (cycles) @(posedge clk);
        streamOn <= 1'b0;
        repeat (4) @(posedge clk);
    endtask

    always @(posedge clk) begin : stimulus
        if (streamOn) begin
            ddcSync    <= $urandom % 2;
            resampSync <= $urandom % 2;
            iDdc       <= $urandom;
            qDdc       <= $urandom;
            iResamp    <= $urandom;
            qResamp    <= $urandom;
            freq       <= $urandom;
            freqError  <= $urandom;
            mag        <= $urandom;
        end else begin
            ddcSync    <= 1'b0;
            resampSync <= 1'b0;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Reference model that compares before it steps
    //////////////////////////////////////////////////////////////////////
    always @(posedge clk) begin : referenceModel
        longint     sampleL, avgL, alphaL, absL;
        int         errInt, shift, ch;
        logic [3:0] sel, mode;
        mode = regShadow[0][3:0];
        if (!arstN) begin
            {mISwap, mQSwap, mFreqWord, mFreqErrWord} = '0;
            {mFreqSample, mAvg, mISym, mQSym, mQDelay} = '0;
            {mDdcSyncD, mSymSync, mHigh, mMagErr, mMagAcc} = '0;
            for (ch = 0; ch < 3; ch++) begin
                mDac[ch]     = '0;
                mDacSync[ch] = 1'b0;
            end
        end else begin
            checkValue("highFreqOffset", highFreqOffset, mHigh);
            checkValue("symSync", symSync, mSymSync);
            if (symSync) begin
                checkValue("iSym", iSym, mISym);
                checkValue("qSym", qSym, mQSym);
            end
            checkValue("dac0Sync", dac0Sync, mDacSync[0]);
            checkValue("dac1Sync", dac1Sync, mDacSync[1]);
            checkValue("dac2Sync", dac2Sync, mDacSync[2]);
            if (dac0Sync) checkValue("dac0Data", dac0Data, mDac[0]);
            if (dac1Sync) checkValue("dac1Data", dac1Data, mDac[1]);
            if (dac2Sync) checkValue("dac2Data", dac2Data, mDac[2]);
            if (wbAck) ackCount++;

            for (ch = 0; ch < 3; ch++) begin
                sel          = regShadow[1][4*ch +: 4];
                mDacSync[ch] = mDdcSyncD;
                case (sel)
                    DAC_Q:         mDac[ch] = mQSwap;
                    DAC_ISYM: begin
                        mDac[ch]     = mISym;
                        mDacSync[ch] = mSymSync;
                    end
                    DAC_QSYM: begin
                        mDac[ch]     = mQSym;
                        mDacSync[ch] = mSymSync;
                    end
                    DAC_FREQ:      mDac[ch] = mFreqWord;
                    DAC_FREQERROR: mDac[ch] = mFreqErrWord;
                    DAC_MAG:       mDac[ch] = mMagAcc[MAG_ACC_W-1 -: SAMPLE_W];
                    DAC_AVGFREQ:   mDac[ch] = mAvg;
                    default:       mDac[ch] = mISwap;
                endcase
            end

            mDdcSyncD = ddcSync;
            mSymSync  = resampSync;
            if (ddcSync) begin
                mISwap       = regShadow[0][4] ? qDdc : iDdc;
                mQSwap       = regShadow[0][4] ? iDdc : qDdc;
                mFreqWord    = {freq, 10'b0};
                mFreqErrWord = {freqError, 10'b0};
                sampleL      = $signed(mFreqSample);
                avgL         = $signed(mAvg);
                alphaL       = regShadow[2][15:0] * 4;  // Q17 weight
                absL         = (avgL < 0) ? -avgL : avgL;
                mHigh        = absL > regShadow[2][31:16];
                avgL         = (sampleL * alphaL + avgL * (131072 - alphaL)) >>> 17;
                mAvg         = avgL[17:0];
                mFreqSample  = {(mode == MODE_OQPSK) ? freq : freqError, 10'b0};
                errInt       = $signed(mMagErr);
                shift        = (regShadow[3][4:0] > 14) ? 0 : 14 - regShadow[3][4:0];
                mMagErr      = {1'b0, mag} - mMagAcc[MAG_ACC_W-1 -: MAG_W+1];
                mMagAcc      = mMagAcc + errInt * (1 << shift);
            end
            if (resampSync) begin
                mISym   = iResamp;
                mQSym   = (mode == MODE_OQPSK) ? mQDelay : qResamp;
                mQDelay = qResamp;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////////////////////////
    initial begin : testSequence
        int          seed;
        int          i;
        logic [31:0] rdata;
        seed = 41;
        i    = $urandom(seed);
        {arstN, wbCyc, wbStb, wbWe, wbAdr, wbSel, wbDatW} = '0;
        {iDdc, qDdc, iResamp, qResamp, ddcSync, resampSync} = '0;
        {freq, freqError, mag, streamOn} = '0;
        for (i = 0; i < 4; i++) regShadow[i] = '0;
        repeat (4) @(posedge clk);
        arstN <= 1'b1;

        for (i = 0; i < 40; i++) begin  // Random byte-enabled writes
            busCycle(1'b1, $urandom % 8, $urandom % 16, $urandom, rdata);
            readCheck(wbAdr);
        end
        for (i = 0; i < 16; i++) readCheck(i);

        for (i = 0; i < 2; i++) begin  // Swap off and then on
            writeReg(REG_CONTROL, (i << 4) | ($urandom % 6));
            writeReg(REG_DACSEL, ((8 + $urandom % 8) << 8) | (DAC_Q << 4) | DAC_I);
            runStream(200);
        end

        writeReg(REG_DACSEL, (DAC_I << 8) | (DAC_QSYM << 4) | DAC_ISYM);
        writeReg(REG_CONTROL, MODE_OQPSK);
        runStream(300);
        writeReg(REG_CONTROL, $urandom % 5);
        runStream(300);

        writeReg(REG_DACSEL, (DAC_MAG << 8) | (DAC_MAG << 4) | DAC_MAG);
        for (i = 0; i < 4; i++) begin
            writeReg(REG_MAGTC, $urandom % 32);
            runStream(400);
        end

        writeReg(REG_DACSEL, (DAC_AVGFREQ << 8) | (DAC_FREQ << 4) | DAC_FREQERROR);
        for (i = 0; i < 6; i++) begin  // Alternate both frequency sources
            writeReg(REG_CONTROL, (i % 2 == 0) ? MODE_OQPSK : $urandom % 5);
            writeReg(REG_FALSELOCK, $urandom);
            runStream(300);
            readCheck(REG_STATUS);
        end

        repeat (2) @(posedge clk);
        checkValue("ackCount", ackCount, accessCount);  // One ack per access
        $display("Run finished: %0d checks, %0d errors", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: demodTop.f
common/demodPkg.sv
src/demodRegs.sv
falseLock/falseLockDetector.sv
src/magFilter.sv
src/oqpskDeskew.sv
dacMux/dacChannel.sv
dacMux/dacMux.sv
src/demodTop.sv
dv/demodTb.sv
